// File: rtl/ipic_pkg.sv
/*
 * Interrupt controller shared definitions
 * Line count, widths, register map and ICSR field positions
 */

package ipic_pkg;

    // --------------------
    // Sizes
    // --------------------
    localparam int IRQ_NUM = 16;        // External request lines
    localparam int VECT_W  = 5;         // Vector number incl. void bit
    localparam int IDX_W   = 4;         // Line index
    localparam int XLEN    = 32;        // Register data

    typedef logic [IRQ_NUM-1:0] irq_vec_t;     // One bit per line
    typedef logic [IDX_W-1:0]   irq_idx_t;
    typedef logic [VECT_W-1:0]  irq_vect_t;    // MSB set means void

    localparam irq_vect_t VOID_VECT = irq_vect_t'(IRQ_NUM);  // Nothing in service

    // --------------------
    // Register map
    // --------------------
    typedef enum logic [2:0] {
        ADDR_CISV  = 3'd0,      // Read only
        ADDR_CICSR = 3'd1,      // Reserved, reads zero
        ADDR_IPR   = 3'd2,      // Write 1 to clear
        ADDR_ISVR  = 3'd3,      // Read only
        ADDR_EOI   = 3'd4,      // Write only
        ADDR_SOI   = 3'd5,      // Write only
        ADDR_IDX   = 3'd6,
        ADDR_ICSR  = 3'd7       // Window selected by IDX
    } ipic_addr_e;

    // ICSR fields
    localparam int ICSR_IP      = 0;    // Pending
    localparam int ICSR_IE      = 1;    // Enable
    localparam int ICSR_IM      = 2;    // Mode, 1 = edge
    localparam int ICSR_INV     = 3;    // Inversion
    localparam int ICSR_IS      = 4;    // In service
    localparam int ICSR_PRV_LSB = 8;
    localparam int ICSR_PRV_MSB = 9;
    localparam int ICSR_LN_LSB  = 12;   // Line number field start

    localparam logic [1:0] PRV_M = 2'd3;    // Machine privilege

endpackage

// File: rtl/ipic_prio_enc.sv
/*
 * Lowest-index set-bit finder
 * Binary tree of two-input stages, valid flag when any bit set
 */

`timescale 1ns/10ps

module ipic_prio_enc #(
    parameter int N = 16                // Input width
) (
    input  logic [N-1:0]         vec_i,
    output logic                 vld_o,     // Any bit set
    output logic [$clog2(N)-1:0] idx_o      // Lowest set bit
);
    localparam int W = $clog2(N);   // Tree depth
    localparam int P = 1 << W;      // Padded width

    logic [P-1:0] vec_pad;
    logic         vld_t [W+1][P];   // Node valid per level
    logic [W-1:0] idx_t [W+1][P];   // Node index per level

    assign vec_pad = P'(vec_i);

    always_comb begin
        for (int l = 0; l <= W; l++) begin
            for (int j = 0; j < P; j++) begin
                vld_t[l][j] = 1'b0;
                idx_t[l][j] = '0;
            end
        end
        for (int j = 0; j < P; j++) vld_t[0][j] = vec_pad[j];  // Leaves
        // Each stage merges pairs, low half wins
        for (int l = 0; l < W; l++) begin
            for (int j = 0; j < (P >> (l + 1)); j++) begin
                vld_t[l+1][j] = vld_t[l][2*j] | vld_t[l][2*j+1];
                idx_t[l+1][j] = vld_t[l][2*j] ? idx_t[l][2*j]
                                              : (idx_t[l][2*j+1] | W'(1 << l));
            end
        end
    end

    assign vld_o = vld_t[W][0];
    assign idx_o = idx_t[W][0];

endmodule

// File: rtl/ipic_line_detect.sv
/*
 * Request line front end
 * Optional two-flop synchroniser, inversion, level and edge detection
 */

`timescale 1ns/10ps

module ipic_line_detect #(
    parameter bit SYNC_EN = 1'b1        // Add two-flop synchroniser
) (
    input  logic               clk,
    input  logic               rst_n,
    input  ipic_pkg::irq_vec_t irq_lines_i,    // Raw external lines
    input  ipic_pkg::irq_vec_t iinvr_i,        // Inversion, next-cycle value
    output ipic_pkg::irq_vec_t irq_lvl_o,      // Active level per line
    output ipic_pkg::irq_vec_t irq_edge_o      // Change into active level
);
    import ipic_pkg::*;

    irq_vec_t lines;        // Lines after optional sync
    irq_vec_t lines_dly;    // Previous cycle

    if (SYNC_EN) begin : g_sync
        irq_vec_t sync_ff;  // First stage
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                sync_ff <= '0;
                lines   <= '0;
            end else begin
                sync_ff <= irq_lines_i;
                lines   <= sync_ff;
            end
        end
    end else begin : g_nosync
        assign lines = irq_lines_i;     // Lines already in clock domain
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) lines_dly <= '0;
        else        lines_dly <= lines;
    end

    assign irq_lvl_o  = lines ^ iinvr_i;
    assign irq_edge_o = (lines ^ lines_dly) & irq_lvl_o;   // Only edges into active level

endmodule

// File: rtl/ipic_pending.sv
/*
 * Interrupt pending register (IPR)
 * Level-follow or edge-latch per line, cleared by IPR, ICSR or SOI
 */

`timescale 1ns/10ps

module ipic_pending (
    input  logic                       clk,
    input  logic                       rst_n,
    input  ipic_pkg::irq_vec_t         irq_lvl_i,
    input  ipic_pkg::irq_vec_t         irq_edge_i,
    input  ipic_pkg::irq_vec_t         imr_i,          // Registered mode
    input  ipic_pkg::irq_vec_t         imr_next_i,     // Mode incl. current write
    input  logic                       ipr_wr_i,       // Write 1 to clear mask
    input  logic                       icsr_wr_i,
    input  logic                       soi_clr_i,
    input  logic [ipic_pkg::XLEN-1:0]  wdata_i,
    input  ipic_pkg::irq_idx_t         idx_i,          // ICSR window
    input  ipic_pkg::irq_idx_t         req_idx_i,      // Line taken by SOI
    output ipic_pkg::irq_vec_t         ipr_o
);
    import ipic_pkg::*;

    irq_vec_t ipr_ff;
    irq_vec_t ipr_next;
    irq_vec_t clr_req;      // Requested clears
    irq_vec_t clr;          // Clears that take effect

    // --------------------
    // Clear requests
    // --------------------
    always_comb begin
        clr_req = '0;
        if (ipr_wr_i) clr_req = wdata_i[IRQ_NUM-1:0];
        if (icsr_wr_i) clr_req[idx_i] = clr_req[idx_i] | wdata_i[ICSR_IP];
        if (soi_clr_i) clr_req[req_idx_i] = 1'b1;
    end

    // Active level holds a level-mode bit set
    assign clr = clr_req & (~irq_lvl_i | imr_next_i);

    always_comb begin
        for (int i = 0; i < IRQ_NUM; i++) begin
            ipr_next[i] = clr[i]    ? 1'b0
                        : ~imr_i[i] ? irq_lvl_i[i]                  // Level follow
                                    : ipr_ff[i] | irq_edge_i[i];    // Edge latch
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) ipr_ff <= '0;
        else        ipr_ff <= ipr_next;
    end

    assign ipr_o = ipr_ff;

endmodule

// File: rtl/ipic_service_fsm.sv
/*
 * Service tracker
 * CISV and ISVR state, SOI and EOI commands, nested priority request
 */

`timescale 1ns/10ps

module ipic_service_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ipic_pkg::irq_vec_t    ipr_i,
    input  ipic_pkg::irq_vec_t    ier_i,
    input  logic                  eoi_wr_i,
    input  logic                  soi_wr_i,
    output ipic_pkg::irq_vect_t   cisv_o,       // Void when idle
    output ipic_pkg::irq_vec_t    isvr_o,
    output logic                  soi_clr_o,    // Clear IPR bit at req_idx_o
    output ipic_pkg::irq_idx_t    req_idx_o,
    output logic                  irq_m_req_o
);
    import ipic_pkg::*;

    irq_vect_t cisv_ff;
    irq_vec_t  isvr_ff;
    irq_vec_t  isvr_eoi;    // ISVR without current line
    irq_vec_t  req_vec;     // Pending and enabled
    logic      req_vld;
    irq_idx_t  req_idx;
    logic      eoi_vld;
    irq_idx_t  eoi_idx;
    logic      serv_vld;
    irq_idx_t  serv_idx;
    logic      start;       // SOI accepted
    logic      finish;      // EOI accepted

    assign req_vec  = ipr_i & ier_i;
    assign serv_vld = ~cisv_ff[VECT_W-1];
    assign serv_idx = cisv_ff[IDX_W-1:0];

    always_comb begin
        isvr_eoi = isvr_ff;
        if (serv_vld) isvr_eoi[serv_idx] = 1'b0;
    end

    ipic_prio_enc #(.N(IRQ_NUM)) u_req_enc (
        .vec_i (req_vec),
        .vld_o (req_vld),
        .idx_o (req_idx)
    );

    // Next in service after EOI
    ipic_prio_enc #(.N(IRQ_NUM)) u_eoi_enc (
        .vec_i (isvr_eoi),
        .vld_o (eoi_vld),
        .idx_o (eoi_idx)
    );

    // Lower index preempts current service
    assign irq_m_req_o = req_vld & (~serv_vld | (req_idx < serv_idx));
    assign start       = soi_wr_i & irq_m_req_o;
    assign finish      = eoi_wr_i & serv_vld;
    assign soi_clr_o   = soi_wr_i & req_vld;
    assign req_idx_o   = req_idx;

    // --------------------
    // Service state
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cisv_ff <= VOID_VECT;
            isvr_ff <= '0;
        end else if (start) begin
            cisv_ff          <= {1'b0, req_idx};
            isvr_ff[req_idx] <= 1'b1;              // Nest on top
        end else if (finish) begin
            cisv_ff <= eoi_vld ? {1'b0, eoi_idx} : VOID_VECT;
            isvr_ff <= isvr_eoi;
        end
    end

    assign cisv_o = cisv_ff;
    assign isvr_o = isvr_ff;

endmodule

// File: rtl/ipic_csr_regs.sv
/*
 * Register file and access decode
 * Write pulses, IDX/IER/IMR/IINVR registers, ICSR window and read mux
 */

`timescale 1ns/10ps

module ipic_csr_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       r_req_i,
    input  logic                       w_req_i,
    input  ipic_pkg::ipic_addr_e       addr_i,
    input  logic [ipic_pkg::XLEN-1:0]  wdata_i,
    input  ipic_pkg::irq_vec_t         ipr_i,
    input  ipic_pkg::irq_vec_t         isvr_i,
    input  ipic_pkg::irq_vect_t        cisv_i,
    output logic [ipic_pkg::XLEN-1:0]  rdata_o,       // Zero without read strobe
    output logic                       ipr_wr_o,
    output logic                       eoi_wr_o,
    output logic                       soi_wr_o,
    output logic                       icsr_wr_o,
    output ipic_pkg::irq_idx_t         idx_o,
    output ipic_pkg::irq_vec_t         ier_o,
    output ipic_pkg::irq_vec_t         imr_o,
    output ipic_pkg::irq_vec_t         imr_next_o,
    output ipic_pkg::irq_vec_t         iinvr_next_o
);
    import ipic_pkg::*;

    logic     idx_wr;
    irq_idx_t idx_ff;
    irq_vec_t ier_ff;
    irq_vec_t ier_next;
    irq_vec_t imr_ff;
    irq_vec_t imr_next;
    irq_vec_t iinvr_ff;
    irq_vec_t iinvr_next;

    // --------------------
    // Write decode
    // --------------------
    always_comb begin
        ipr_wr_o  = 1'b0;
        eoi_wr_o  = 1'b0;
        soi_wr_o  = 1'b0;
        idx_wr    = 1'b0;
        icsr_wr_o = 1'b0;
        if (w_req_i) begin
            case (addr_i)
                ADDR_IPR:  ipr_wr_o  = 1'b1;
                ADDR_EOI:  eoi_wr_o  = 1'b1;
                ADDR_SOI:  soi_wr_o  = 1'b1;
                ADDR_IDX:  idx_wr    = 1'b1;
                ADDR_ICSR: icsr_wr_o = 1'b1;
                default: ;                  // CISV, CICSR, ISVR ignore writes
            endcase
        end
    end

    // ICSR write touches one line at IDX
    always_comb begin
        ier_next   = ier_ff;
        imr_next   = imr_ff;
        iinvr_next = iinvr_ff;
        if (icsr_wr_o) begin
            ier_next[idx_ff]   = wdata_i[ICSR_IE];
            imr_next[idx_ff]   = wdata_i[ICSR_IM];
            iinvr_next[idx_ff] = wdata_i[ICSR_INV];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_ff   <= '0;
            ier_ff   <= '0;
            imr_ff   <= '0;
            iinvr_ff <= '0;
        end else begin
            if (idx_wr) idx_ff <= wdata_i[IDX_W-1:0];
            ier_ff   <= ier_next;
            imr_ff   <= imr_next;
            iinvr_ff <= iinvr_next;
        end
    end

    // --------------------
    // Read mux
    // --------------------
    always_comb begin
        rdata_o = '0;
        if (r_req_i) begin
            case (addr_i)
                ADDR_CISV:  rdata_o = XLEN'(cisv_i);
                ADDR_IPR:   rdata_o = XLEN'(ipr_i);
                ADDR_ISVR:  rdata_o = XLEN'(isvr_i);
                ADDR_IDX:   rdata_o = XLEN'(idx_ff);
                ADDR_ICSR: begin
                    rdata_o[ICSR_IP]  = ipr_i[idx_ff];
                    rdata_o[ICSR_IE]  = ier_ff[idx_ff];
                    rdata_o[ICSR_IM]  = imr_ff[idx_ff];
                    rdata_o[ICSR_INV] = iinvr_ff[idx_ff];
                    rdata_o[ICSR_IS]  = isvr_i[idx_ff];
                    rdata_o[ICSR_PRV_MSB:ICSR_PRV_LSB] = PRV_M;
                    rdata_o[ICSR_LN_LSB +: IDX_W]      = idx_ff;  // Line number
                end
                ADDR_CICSR, ADDR_EOI, ADDR_SOI: rdata_o = '0;
                default: rdata_o = '0;
            endcase
        end
    end

    assign idx_o        = idx_ff;
    assign ier_o        = ier_ff;
    assign imr_o        = imr_ff;
    assign imr_next_o   = imr_next;
    assign iinvr_next_o = iinvr_next;

endmodule

// File: rtl/ipic_top.sv
/*
 * Integrated programmable interrupt controller, top level
 * Sixteen request lines behind a strobe-based register port
 */

`timescale 1ns/10ps

module ipic_top #(
    parameter bit SYNC_EN = 1'b1        // Synchronise request lines
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  ipic_pkg::irq_vec_t         irq_lines_i,
    input  logic                       csr_r_req_i,
    input  logic                       csr_w_req_i,
    input  ipic_pkg::ipic_addr_e       csr_addr_i,
    input  logic [ipic_pkg::XLEN-1:0]  csr_wdata_i,
    output logic [ipic_pkg::XLEN-1:0]  csr_rdata_o,
    output logic                       irq_m_req_o     // Level request to core
);
    import ipic_pkg::*;

    irq_vec_t  irq_lvl;
    irq_vec_t  irq_edge;
    irq_vec_t  ipr;
    irq_vec_t  isvr;
    irq_vec_t  ier;
    irq_vec_t  imr;
    irq_vec_t  imr_next;
    irq_vec_t  iinvr_next;
    irq_vect_t cisv;
    irq_idx_t  idx;
    irq_idx_t  req_idx;
    logic      ipr_wr;
    logic      eoi_wr;
    logic      soi_wr;
    logic      icsr_wr;
    logic      soi_clr;

    ipic_line_detect #(.SYNC_EN(SYNC_EN)) u_line_detect (
        .clk(clk), .rst_n(rst_n),
        .irq_lines_i(irq_lines_i), .iinvr_i(iinvr_next),
        .irq_lvl_o(irq_lvl), .irq_edge_o(irq_edge)
    );

    ipic_pending u_pending (
        .clk(clk), .rst_n(rst_n),
        .irq_lvl_i(irq_lvl), .irq_edge_i(irq_edge),
        .imr_i(imr), .imr_next_i(imr_next),
        .ipr_wr_i(ipr_wr), .icsr_wr_i(icsr_wr), .soi_clr_i(soi_clr),
        .wdata_i(csr_wdata_i), .idx_i(idx), .req_idx_i(req_idx),
        .ipr_o(ipr)
    );

    ipic_service_fsm u_service (
        .clk(clk), .rst_n(rst_n),
        .ipr_i(ipr), .ier_i(ier),
        .eoi_wr_i(eoi_wr), .soi_wr_i(soi_wr),
        .cisv_o(cisv), .isvr_o(isvr),
        .soi_clr_o(soi_clr), .req_idx_o(req_idx),
        .irq_m_req_o(irq_m_req_o)
    );

    ipic_csr_regs u_csr_regs (
        .clk(clk), .rst_n(rst_n),
        .r_req_i(csr_r_req_i), .w_req_i(csr_w_req_i),
        .addr_i(csr_addr_i), .wdata_i(csr_wdata_i),
        .ipr_i(ipr), .isvr_i(isvr), .cisv_i(cisv),
        .rdata_o(csr_rdata_o),
        .ipr_wr_o(ipr_wr), .eoi_wr_o(eoi_wr), .soi_wr_o(soi_wr), .icsr_wr_o(icsr_wr),
        .idx_o(idx), .ier_o(ier), .imr_o(imr),
        .imr_next_o(imr_next), .iinvr_next_o(iinvr_next)
    );

endmodule

// File: sim/ipic_tb_chk.sv
/*
 * Service tracker checker
 * Concurrent assertions bound into the service FSM
 */

`timescale 1ns/10ps

module ipic_tb_chk (
    input logic                clk,
    input logic                rst_n,
    input ipic_pkg::irq_vec_t  ipr_i,
    input ipic_pkg::irq_vec_t  isvr_i,
    input ipic_pkg::irq_vect_t cisv_i,
    input logic                soi_wr_i,
    input logic                irq_m_req_i
);
    import ipic_pkg::*;

    // Request needs something pending
    a_req_pending: assert property (@(posedge clk) disable iff (!rst_n)
        irq_m_req_i |-> (ipr_i != '0))
        else $error("Interrupt request high while IPR is empty");

    // Void vector while nothing in service
    a_cisv_void: assert property (@(posedge clk) disable iff (!rst_n)
        (isvr_i == '0) |-> (cisv_i == VOID_VECT))
        else $error("CISV not void with ISVR empty");

    // At most one new in-service line per SOI
    a_soi_one: assert property (@(posedge clk) disable iff (!rst_n)
        soi_wr_i |=> $onehot0(isvr_i & ~$past(isvr_i)))
        else $error("SOI set more than one ISVR bit");

endmodule

bind ipic_service_fsm ipic_tb_chk u_chk (
    .clk(clk), .rst_n(rst_n),
    .ipr_i(ipr_i), .isvr_i(isvr_o), .cisv_i(cisv_o),
    .soi_wr_i(soi_wr_i), .irq_m_req_i(irq_m_req_o)
);

// File: sim/ipic_tb.sv
/*
 * Interrupt controller testbench
 * Table-driven register accesses and line changes with checked responses
 */

`timescale 1ns/10ps

module ipic_tb;
    import ipic_pkg::*;

    localparam logic [1:0] OP_RD   = 2'd1;
    localparam logic [1:0] OP_WR   = 2'd2;
    localparam int         MARGIN  = 20;    // Extra cycles before timeout

    // One table entry
    typedef struct packed {
        irq_vec_t        lines;
        logic [1:0]      op;
        ipic_addr_e      addr;
        logic [XLEN-1:0] wdata;
        int              idle;          // Cycles before the access
        logic [XLEN-1:0] exp_rdata;
        logic            exp_irq;
    } step_t;

    logic            clk;
    logic            rst_n;
    irq_vec_t        irq_lines;
    logic            csr_r_req;
    logic            csr_w_req;
    ipic_addr_e      csr_addr;
    logic [XLEN-1:0] csr_wdata;
    logic [XLEN-1:0] csr_rdata_o;
    logic            irq_m_req_o;

    step_t steps[$];
    int    err_cnt     = 0;
    int    cycles      = 0;
    int    cycle_limit = 0;

    ipic_top #(.SYNC_EN(1'b1)) dut (
        .clk(clk), .rst_n(rst_n),
        .irq_lines_i(irq_lines),
        .csr_r_req_i(csr_r_req), .csr_w_req_i(csr_w_req),
        .csr_addr_i(csr_addr), .csr_wdata_i(csr_wdata),
        .csr_rdata_o(csr_rdata_o), .irq_m_req_o(irq_m_req_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------
    // Timeout
    // --------------------
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: the stimulus table did not finish within %0d cycles", cycle_limit);
            $display("Finished with errors");
            $fatal(1, "Simulation stopped on timeout");
        end
    end

    task automatic stop_on_error(input string what);
        err_cnt++;
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_rdata(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("Fail at %0t ns: csr_rdata_o got 0x%08h, expected 0x%08h",
                                    $time, got, exp));
    endtask

    task automatic check_irq(input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("Fail at %0t ns: irq_m_req_o got %b, expected %b",
                                    $time, got, exp));
    endtask

    task automatic add_step(input irq_vec_t lines, input logic [1:0] op, input ipic_addr_e addr,
                            input logic [XLEN-1:0] wdata, input int idle,
                            input logic [XLEN-1:0] exp_rdata, input logic exp_irq);
        step_t s;
        s.lines     = lines;
        s.op        = op;
        s.addr      = addr;
        s.wdata     = wdata;
        s.idle      = idle;
        s.exp_rdata = exp_rdata;
        s.exp_irq   = exp_irq;
        steps.push_back(s);
    endtask

    // Lines first, idle wait, then one access cycle checked mid-cycle
    task automatic apply_step(input step_t s);
        irq_lines = s.lines;
        csr_r_req = 1'b0;
        csr_w_req = 1'b0;
        repeat (s.idle) begin
            @(posedge clk);
            #1;
        end
        csr_r_req = (s.op == OP_RD);
        csr_w_req = (s.op == OP_WR);
        csr_addr  = s.addr;
        csr_wdata = s.wdata;
        @(negedge clk);                 // Outputs settled here
        check_rdata(csr_rdata_o, s.exp_rdata);
        check_irq(irq_m_req_o, s.exp_irq);
        @(posedge clk);
        #1;
        csr_r_req = 1'b0;
        csr_w_req = 1'b0;
    endtask

    // --------------------
    // Stimulus table
    // --------------------
    task automatic build_table();
        // Reset values, ICSR shows PRV_M only
        add_step(16'h0000, OP_RD, ADDR_CISV,  32'h0, 0, 32'h0000_0010, 1'b0);
        add_step(16'h0000, OP_RD, ADDR_CICSR, 32'h0, 0, 32'h0000_0000, 1'b0);
        add_step(16'h0000, OP_RD, ADDR_IPR,   32'h0, 0, 32'h0000_0000, 1'b0);
        add_step(16'h0000, OP_RD, ADDR_ISVR,  32'h0, 0, 32'h0000_0000, 1'b0);
        add_step(16'h0000, OP_RD, ADDR_IDX,   32'h0, 0, 32'h0000_0000, 1'b0);
        add_step(16'h0000, OP_RD, ADDR_ICSR,  32'h0, 0, 32'h0000_0300, 1'b0);
        // Line 5 window; inverting a low line in level mode sets IP at once
        add_step(16'h0000, OP_WR, ADDR_IDX,   32'h5, 0, 32'h0000_0000, 1'b0);
        add_step(16'h0000, OP_WR, ADDR_ICSR,  32'hE, 0, 32'h0000_0000, 1'b0);
        add_step(16'h0000, OP_RD, ADDR_ICSR,  32'h0, 0, 32'h0000_530F, 1'b1);
        add_step(16'h0000, OP_RD, ADDR_IDX,   32'h0, 0, 32'h0000_0005, 1'b1);
        add_step(16'h0000, OP_RD, ADDR_IPR,   32'h0, 0, 32'h0000_0020, 1'b1);
        add_step(16'h0000, OP_WR, ADDR_ICSR,  32'hD, 0, 32'h0000_0000, 1'b1);  // Off, clear IP
        add_step(16'h0000, OP_RD, ADDR_ICSR,  32'h0, 0, 32'h0000_530C, 1'b0);
        // Line 3 level mode
        add_step(16'h0000, OP_WR, ADDR_IDX,   32'h3, 0, 32'h0000_0000, 1'b0);
        add_step(16'h0000, OP_WR, ADDR_ICSR,  32'h2, 0, 32'h0000_0000, 1'b0);
        add_step(16'h0008, OP_RD, ADDR_IPR,   32'h0, 3, 32'h0000_0008, 1'b1);
        add_step(16'h0008, OP_RD, ADDR_ICSR,  32'h0, 0, 32'h0000_3303, 1'b1);
        add_step(16'h0000, OP_RD, ADDR_IPR,   32'h0, 3, 32'h0000_0000, 1'b0);
        // Same line inverted
        add_step(16'h0000, OP_WR, ADDR_ICSR,  32'hA, 0, 32'h0000_0000, 1'b0);
        add_step(16'h0000, OP_RD, ADDR_IPR,   32'h0, 0, 32'h0000_0008, 1'b1);
        add_step(16'h0008, OP_RD, ADDR_IPR,   32'h0, 3, 32'h0000_0000, 1'b0);
        add_step(16'h0000, OP_RD, ADDR_IPR,   32'h0, 3, 32'h0000_0008, 1'b1);
        add_step(16'h0000, OP_WR, ADDR_ICSR,  32'h0, 0, 32'h0000_0000, 1'b1);
        add_step(16'h0000, OP_RD, ADDR_IPR,   32'h0, 0, 32'h0000_0000, 1'b0);
        // Line 7 edge mode, one-cycle pulse
        add_step(16'h0000, OP_WR, ADDR_IDX,   32'h7, 0, 32'h0000_0000, 1'b0);
        add_step(16'h0000, OP_WR, ADDR_ICSR,  32'h6, 0, 32'h0000_0000, 1'b0);
        add_step(16'h0080, OP_RD, ADDR_IPR,   32'h0, 0, 32'h0000_0000, 1'b0);
        add_step(16'h0000, OP_RD, ADDR_IPR,   32'h0, 3, 32'h0000_0080, 1'b1);  // Latched
        add_step(16'h0000, OP_RD, ADDR_ICSR,  32'h0, 0, 32'h0000_7307, 1'b1);
        add_step(16'h0000, OP_WR, ADDR_IPR,  32'h80, 0, 32'h0000_0000, 1'b1);
        add_step(16'h0000, OP_RD, ADDR_IPR,   32'h0, 0, 32'h0000_0000, 1'b0);
        add_step(16'h0000, OP_WR, ADDR_ICSR,  32'h0, 0, 32'h0000_0000, 1'b0);
        // Enable lines 2, 9 and 1 in level mode
        add_step(16'h0000, OP_WR, ADDR_IDX,   32'h2, 0, 32'h0000_0000, 1'b0);
        add_step(16'h0000, OP_WR, ADDR_ICSR,  32'h2, 0, 32'h0000_0000, 1'b0);
        add_step(16'h0000, OP_WR, ADDR_IDX,   32'h9, 0, 32'h0000_0000, 1'b0);
        add_step(16'h0000, OP_WR, ADDR_ICSR,  32'h2, 0, 32'h0000_0000, 1'b0);
        add_step(16'h0000, OP_WR, ADDR_IDX,   32'h1, 0, 32'h0000_0000, 1'b0);
        add_step(16'h0000, OP_WR, ADDR_ICSR,  32'h2, 0, 32'h0000_0000, 1'b0);
        // Nested service
        add_step(16'h0204, OP_RD, ADDR_IPR,   32'h0, 3, 32'h0000_0204, 1'b1);
        add_step(16'h0204, OP_WR, ADDR_SOI,   32'h0, 0, 32'h0000_0000, 1'b1);
        add_step(16'h0204, OP_RD, ADDR_CISV,  32'h0, 0, 32'h0000_0002, 1'b0);
        add_step(16'h0204, OP_RD, ADDR_ISVR,  32'h0, 0, 32'h0000_0004, 1'b0);
        add_step(16'h0204, OP_RD, ADDR_IPR,   32'h0, 0, 32'h0000_0204, 1'b0);  // Level held
        add_step(16'h0206, OP_RD, ADDR_IPR,   32'h0, 3, 32'h0000_0206, 1'b1);  // Line 1 preempts
        add_step(16'h0206, OP_WR, ADDR_SOI,   32'h0, 0, 32'h0000_0000, 1'b1);
        add_step(16'h0206, OP_RD, ADDR_CISV,  32'h0, 0, 32'h0000_0001, 1'b0);
        add_step(16'h0206, OP_RD, ADDR_ICSR,  32'h0, 0, 32'h0000_1313, 1'b0);
        add_step(16'h0206, OP_WR, ADDR_EOI,   32'h0, 0, 32'h0000_0000, 1'b0);
        add_step(16'h0206, OP_RD, ADDR_CISV,  32'h0, 0, 32'h0000_0002, 1'b1);
        add_step(16'h0206, OP_RD, ADDR_ISVR,  32'h0, 0, 32'h0000_0004, 1'b1);
        add_step(16'h0206, OP_WR, ADDR_EOI,   32'h0, 0, 32'h0000_0000, 1'b1);
        add_step(16'h0206, OP_RD, ADDR_CISV,  32'h0, 0, 32'h0000_0010, 1'b1);
        add_step(16'h0000, OP_RD, ADDR_ISVR,  32'h0, 3, 32'h0000_0000, 1'b0);
        add_step(16'h0000, OP_RD, ADDR_IPR,   32'h0, 0, 32'h0000_0000, 1'b0);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int total;
        rst_n     = 1'b0;
        irq_lines = '0;
        csr_r_req = 1'b0;
        csr_w_req = 1'b0;
        csr_addr  = ADDR_CISV;
        csr_wdata = '0;
        build_table();
        total = 2;                      // Reset cycles
        foreach (steps[i]) total += steps[i].idle + 2;
        cycle_limit = total + MARGIN;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (steps[i]) apply_step(steps[i]);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "Errors found");
        end
    end

endmodule

// File: filelist.f
rtl/ipic_pkg.sv
rtl/ipic_prio_enc.sv
rtl/ipic_line_detect.sv
rtl/ipic_pending.sv
rtl/ipic_service_fsm.sv
rtl/ipic_csr_regs.sv
rtl/ipic_top.sv
sim/ipic_tb_chk.sv
sim/ipic_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the interrupt controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps -f filelist.f \
    --top-module ipic_tb --Mdir obj_dir -o ipic_sim || { echo "Build failed"; exit 1; }
sim_out=$(./obj_dir/ipic_sim 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -qx "Finished with no errors" && exit 0 || exit 1
